// File: files.f
+incdir+.
cpu_isa_pkg.sv
cpu_bus_pkg.sv
cpu_fetch.sv
cpu_decode.sv
cpu_regfile.sv
cpu_execute.sv
cpu_writeback.sv
cpu_top.sv
tb_cpu_top.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - files:
      - cpu_isa_pkg.sv
      - cpu_bus_pkg.sv
      - cpu_fetch.sv
      - cpu_decode.sv
      - cpu_regfile.sv
      - cpu_execute.sv
      - cpu_writeback.sv
      - cpu_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_cpu_top.sv

// File: tb_cpu_programs.svh
localparam logic [3:0] R_ZERO = 4'd0;
localparam logic [3:0] R_A    = 4'd1;
localparam logic [3:0] R_B    = 4'd2;
localparam logic [3:0] R_C    = 4'd3;
localparam logic [3:0] R_D    = 4'd4;
localparam logic [3:0] R_SL   = 4'd12;
localparam logic [3:0] R_N    = 4'd14;

localparam logic [2:0] OP_ADD   = 3'd0;
localparam logic [2:0] OP_SUB   = 3'd1;
localparam logic [2:0] OP_OR    = 3'd2;
localparam logic [2:0] OP_XOR   = 3'd4;
localparam logic [2:0] OP_RESV  = 3'd5;
localparam logic [2:0] OP_CLAMP = 3'd6;
localparam logic [2:0] OP_MUL   = 3'd7;

// Test table with programs and expected stores
string       test_name [NUM_TESTS];
logic [31:0] prog_tab  [NUM_TESTS][PROG_WORDS];
int          prog_len  [NUM_TESTS];
int          exp_cnt   [NUM_TESTS];
logic [31:0] exp_addr  [NUM_TESTS][MAX_STORES];
logic [31:0] exp_data  [NUM_TESTS][MAX_STORES];

function automatic logic [31:0] imm_inst(input logic [3:0] rd, input logic [2:0] op,
                                         input logic [3:0] rs, input logic [15:0] imm,
                                         input logic st);
    return {3'b000, st, rd, op, rs, 1'b1, imm};
endfunction

function automatic logic [31:0] reg_inst(input logic [3:0] rd, input logic [2:0] op,
                                         input logic [3:0] rs, input logic [3:0] rt,
                                         input logic st, input logic ld, input logic rpt);
    return {3'b000, st, rd, op, rs, 1'b0, 3'b000, rpt, rt, 6'd0, ld, 1'b0};
endfunction

function automatic logic [31:0] sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
endfunction

// R bus memory contents
function automatic logic [31:0] rbus_word(input logic [31:0] addr);
    return addr * 32'd3 + 32'd7;
endfunction

task automatic add_word(input int t, input logic [31:0] w);
    prog_tab[t][prog_len[t]] = w;
    prog_len[t]++;
endtask

task automatic add_nops(input int t, input int n);
    for (int i = 0; i < n; i++) begin
        add_word(t, 32'd0);
    end
endtask

task automatic add_store(input int t, input logic [31:0] addr, input logic [31:0] data);
    exp_addr[t][exp_cnt[t]] = addr;
    exp_data[t][exp_cnt[t]] = data;
    exp_cnt[t]++;
endtask

task automatic build_tests();
    logic [31:0] a;
    logic [31:0] b;
    for (int t = 0; t < NUM_TESTS; t++) begin
        prog_len[t] = 0;
        exp_cnt[t]  = 0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog_tab[t][i] = 32'd0;
        end
    end
    a = sext16(16'($urandom()));
    b = sext16(16'($urandom()));

    test_name[0] = "alu_ops";
    add_word(0, imm_inst(R_SL, OP_ADD, R_ZERO, 16'h0100, 1'b0));
    add_word(0, imm_inst(R_A, OP_ADD, R_ZERO, a[15:0], 1'b0));
    add_word(0, imm_inst(R_B, OP_ADD, R_ZERO, b[15:0], 1'b0));
    add_nops(0, 2);
    for (int op = 0; op < 5; op++) begin
        add_word(0, reg_inst(R_C, 3'(op), R_A, R_B, 1'b1, 1'b0, 1'b0));
    end
    add_store(0, 32'h100, a + b);
    add_store(0, 32'h100, a - b);
    add_store(0, 32'h100, a | b);
    add_store(0, 32'h100, a & b);
    add_store(0, 32'h100, a ^ b);

    test_name[1] = "sign_ext_zero";
    add_word(1, imm_inst(R_SL, OP_ADD, R_ZERO, 16'h0020, 1'b0));
    add_word(1, imm_inst(R_A, OP_ADD, R_ZERO, 16'h8001, 1'b1));
    add_word(1, imm_inst(R_ZERO, OP_ADD, R_ZERO, 16'h1234, 1'b0));
    add_nops(1, 2);
    add_word(1, imm_inst(R_B, OP_OR, R_ZERO, 16'hFFFF, 1'b1));
    add_word(1, reg_inst(R_C, OP_XOR, R_A, R_ZERO, 1'b1, 1'b0, 1'b0));
    add_word(1, reg_inst(R_D, OP_ADD, R_ZERO, R_ZERO, 1'b1, 1'b0, 1'b0));
    add_store(1, 32'h20, sext16(16'h8001));
    add_store(1, 32'h20, sext16(16'hFFFF));
    add_store(1, 32'h20, sext16(16'h8001));
    add_store(1, 32'h20, 32'd0);

    test_name[2] = "r_load";
    add_word(2, imm_inst(R_SL, OP_ADD, R_ZERO, 16'h0040, 1'b0));
    add_word(2, imm_inst(R_A, OP_ADD, R_ZERO, 16'h0010, 1'b0));
    add_word(2, imm_inst(R_B, OP_ADD, R_ZERO, 16'h0005, 1'b0));
    add_nops(2, 2);
    add_word(2, reg_inst(R_C, OP_ADD, R_A, R_B, 1'b1, 1'b1, 1'b0));
    add_word(2, reg_inst(R_D, OP_SUB, R_B, R_ZERO, 1'b1, 1'b1, 1'b0));
    add_store(2, 32'h40, rbus_word(32'h10) + 32'd5);
    add_store(2, 32'h40, rbus_word(32'h5));

    // Repeated B - N sees n count down 3, 2, 1, 0
    test_name[3] = "repeat";
    add_word(3, imm_inst(R_SL, OP_ADD, R_ZERO, 16'h0080, 1'b0));
    add_word(3, imm_inst(R_N, OP_ADD, R_ZERO, 16'd3, 1'b0));
    add_word(3, imm_inst(R_B, OP_ADD, R_ZERO, 16'd10, 1'b0));
    add_nops(3, 2);
    add_word(3, reg_inst(R_A, OP_SUB, R_B, R_N, 1'b1, 1'b0, 1'b1));
    add_word(3, imm_inst(R_C, OP_ADD, R_B, 16'd1, 1'b1));
    add_nops(3, 2);
    add_word(3, reg_inst(R_D, OP_OR, R_N, R_ZERO, 1'b1, 1'b0, 1'b0));
    for (int k = 3; k >= 0; k--) begin
        add_store(3, 32'h80, 32'd10 - 32'(k));
    end
    add_store(3, 32'h80, 32'd11);
    add_store(3, 32'h80, 32'd0);

    test_name[4] = "reserved_jump";
    add_word(4, imm_inst(R_SL, OP_ADD, R_ZERO, 16'h00C0, 1'b0));
    add_word(4, imm_inst(R_A, OP_ADD, R_ZERO, 16'h0055, 1'b0));
    add_word(4, imm_inst(R_B, OP_ADD, R_ZERO, 16'h0033, 1'b0));
    add_nops(4, 2);
    add_word(4, reg_inst(R_C, OP_RESV, R_A, R_B, 1'b1, 1'b0, 1'b0));
    add_word(4, reg_inst(R_C, OP_CLAMP, R_A, R_B, 1'b1, 1'b0, 1'b0));
    add_word(4, imm_inst(R_C, OP_MUL, R_A, 16'd7, 1'b1));
    add_word(4, imm_inst(R_A, OP_ADD, R_ZERO, 16'h1234, 1'b1) | 32'h8000_0000);
    add_nops(4, 2);
    add_word(4, reg_inst(R_D, OP_OR, R_A, R_ZERO, 1'b1, 1'b0, 1'b0));
    for (int k = 0; k < 3; k++) begin
        add_store(4, 32'hC0, 32'd0);
    end
    add_store(4, 32'hC0, 32'h55);
endtask

// File: tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top;

    localparam int NUM_TESTS   = 5;
    localparam int PROG_WORDS  = 24;
    localparam int MAX_STORES  = 8;
    localparam int MEM_WORDS   = 64;
    localparam int END_PC      = PROG_WORDS + 4;
    localparam int WAIT_CYCLES = 200;

    logic        clk;
    logic        rst;
    logic [31:0] p_data;
    logic [31:0] p_addr;
    logic [31:0] r_data;
    logic [31:0] r_addr;
    logic        r_rd;
    logic [31:0] c_addr;
    logic [31:0] c_data;
    logic        c_we;

    logic [31:0] prog_mem [MEM_WORDS];
    logic [31:0] st_addr_q [$];
    logic [31:0] st_data_q [$];
    int          test_errs;
    int          pass_cnt;
    int          fail_cnt;

    `include "tb_cpu_programs.svh"

    cpu_top #(
        .RESET_PC (32'd0)
    ) i_cpu_top (
        .clk      (clk),
        .rst      (rst),
        .p_data_i (p_data),
        .p_addr_o (p_addr),
        .r_data_i (r_data),
        .r_addr_o (r_addr),
        .r_rd_o   (r_rd),
        .c_addr_o (c_addr),
        .c_data_o (c_data),
        .c_we_o   (c_we)
    );

    always #50 clk = ~clk;

    // Both memories answer in the same cycle
    assign p_data = (p_addr < MEM_WORDS) ? prog_mem[p_addr[5:0]] : 32'd0;
    assign r_data = r_rd ? rbus_word(r_addr) : 32'd0;

    // C bus store monitor
    always @(posedge clk) begin
        if (!rst && c_we) begin
            st_addr_q.push_back(c_addr);
            st_data_q.push_back(c_data);
        end
    end

    task automatic check_val(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("ERR %s expected 0x%08h actual 0x%08h", what, exp_v, act_v);
            test_errs++;
        end
    endtask

    task automatic load_program(input int t);
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog_mem[i] <= (i < PROG_WORDS) ? prog_tab[t][i] : 32'd0;
        end
    endtask

    task automatic reset_and_check(input int t);
        @(posedge clk);
        rst <= 1'b1;
        load_program(t);
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            if (i == 4) begin
                rst <= 1'b0;
                st_addr_q.delete();
                st_data_q.delete();
            end
            @(negedge clk);
            check_val({test_name[t], " reset pc"}, 32'd0, p_addr);
            check_val({test_name[t], " reset c_we"}, 32'd0, {31'd0, c_we});
            check_val({test_name[t], " reset r_rd"}, 32'd0, {31'd0, r_rd});
        end
        // No repeat in the first words, so pc steps by one
        for (int k = 1; k < 4; k++) begin
            @(negedge clk);
            check_val({test_name[t], " pc step"}, 32'(k), p_addr);
        end
    endtask

    task automatic run_test(input int t);
        int waited;
        test_errs = 0;
        reset_and_check(t);
        waited = 0;
        while (st_addr_q.size() < exp_cnt[t] && waited < WAIT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (st_addr_q.size() < exp_cnt[t]) begin
            $display("%s: fewer stores than expected, %0d of %0d arrived before the timeout",
                     test_name[t], st_addr_q.size(), exp_cnt[t]);
            test_errs++;
        end else begin
            while (p_addr < END_PC && waited < WAIT_CYCLES) begin
                @(negedge clk);
                waited++;
            end
            if (p_addr < END_PC) begin
                $display("%s: program counter never reached the end of the program",
                         test_name[t]);
                test_errs++;
            end
            check_val({test_name[t], " store count"}, 32'(exp_cnt[t]), 32'(st_addr_q.size()));
            for (int i = 0; i < exp_cnt[t]; i++) begin
                check_val($sformatf("%s store %0d addr", test_name[t], i),
                          exp_addr[t][i], st_addr_q[i]);
                check_val($sformatf("%s store %0d data", test_name[t], i),
                          exp_data[t][i], st_data_q[i]);
            end
        end
        if (test_errs == 0) begin
            $display("PASS %s", test_name[t]);
            pass_cnt++;
        end else begin
            $display("FAIL %s with %0d errors", test_name[t], test_errs);
            fail_cnt++;
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        pass_cnt  = 0;
        fail_cnt  = 0;
        test_errs = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog_mem[i] = 32'd0;
        end
        void'($urandom(31544));
        build_tests();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_isa_pkg::*, cpu_bus_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'd0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] p_data_i,
    output logic [31:0] p_addr_o,
    input  logic [31:0] r_data_i,
    output logic [31:0] r_addr_o,
    output logic        r_rd_o,
    output logic [31:0] c_addr_o,
    output logic [31:0] c_data_o,
    output logic        c_we_o
);

    logic        hold;
    logic        dec_n;
    logic        n_zero;
    dcd_t        dcd;
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic [31:0] sl_val;
    load_req_t   load_req;
    reg_sel_e    ex_rd_sel;
    logic        ex_store;
    logic [31:0] ex_result;
    reg_sel_e    wb_sel;
    logic [31:0] wb_val;
    store_req_t  store_req;

    cpu_fetch #(
        .RESET_PC (RESET_PC)
    ) i_cpu_fetch (
        .clk      (clk),
        .rst      (rst),
        .hold_i   (hold),
        .p_addr_o (p_addr_o)
    );

    cpu_decode i_cpu_decode (
        .clk      (clk),
        .rst      (rst),
        .inst_i   (p_data_i),
        .n_zero_i (n_zero),
        .dcd_o    (dcd),
        .hold_o   (hold),
        .dec_n_o  (dec_n)
    );

    cpu_regfile i_cpu_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs_sel_i (dcd.rs),
        .rt_sel_i (dcd.rt),
        .wb_sel_i (wb_sel),
        .wb_val_i (wb_val),
        .dec_n_i  (dec_n),
        .rs_val_o (rs_val),
        .rt_val_o (rt_val),
        .sl_val_o (sl_val),
        .n_zero_o (n_zero)
    );

    cpu_execute i_cpu_execute (
        .clk      (clk),
        .rst      (rst),
        .dcd_i    (dcd),
        .rs_val_i (rs_val),
        .rt_val_i (rt_val),
        .r_data_i (r_data_i),
        .load_o   (load_req),
        .rd_sel_o (ex_rd_sel),
        .store_o  (ex_store),
        .result_o (ex_result)
    );

    cpu_writeback i_cpu_writeback (
        .rd_sel_i (ex_rd_sel),
        .store_i  (ex_store),
        .result_i (ex_result),
        .sl_val_i (sl_val),
        .wb_sel_o (wb_sel),
        .wb_val_o (wb_val),
        .store_o  (store_req)
    );

    assign r_rd_o   = load_req.rd;
    assign r_addr_o = load_req.addr;
    assign c_we_o   = store_req.we;
    assign c_addr_o = store_req.addr;
    assign c_data_o = store_req.data;

endmodule

// File: cpu_writeback.sv
`timescale 1ns/1ps

module cpu_writeback import cpu_isa_pkg::*, cpu_bus_pkg::*; (
    input  reg_sel_e    rd_sel_i,
    input  logic        store_i,
    input  logic [31:0] result_i,
    input  logic [31:0] sl_val_i,
    output reg_sel_e    wb_sel_o,
    output logic [31:0] wb_val_o,
    output store_req_t  store_o
);

    // Register write port, select 0 is dropped in the register file
    assign wb_sel_o = rd_sel_i;
    assign wb_val_o = result_i;

    // Store goes to the address currently held in sl.
    // An R bus write would have to be arbitrated against loads here.
    assign store_o.we   = store_i;
    assign store_o.addr = sl_val_i;
    assign store_o.data = result_i;

endmodule

// File: cpu_execute.sv
`timescale 1ns/1ps

module cpu_execute import cpu_isa_pkg::*, cpu_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  dcd_t        dcd_i,
    input  logic [31:0] rs_val_i,
    input  logic [31:0] rt_val_i,
    input  logic [31:0] r_data_i,
    output load_req_t   load_o,
    output reg_sel_e    rd_sel_o,
    output logic        store_o,
    output logic [31:0] result_o
);

    // Memory stage copy, aligned with the registered operands
    dcd_t        mem_q;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_res;
    reg_sel_e    rd_sel_q;
    logic        store_q;
    logic [31:0] result_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_q <= DCD_NOP;
        end else begin
            mem_q <= dcd_i;
        end
    end

    // R bus address comes straight from rs
    assign load_o.rd   = mem_q.load;
    assign load_o.addr = rs_val_i;

    assign op_a = mem_q.load ? r_data_i : rs_val_i;
    assign op_b = mem_q.imm_en ? mem_q.imm : rt_val_i;

    always_comb begin
        case (mem_q.op)
            ALU_ADD: alu_res = op_a + op_b;
            ALU_SUB: alu_res = op_a - op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            // Clamp and mul not implemented
            default: alu_res = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_sel_q <= SEL_ZERO;
            store_q  <= 1'b0;
        end else begin
            rd_sel_q <= mem_q.rd;
            store_q  <= mem_q.store;
        end
    end

    always_ff @(posedge clk) begin
        result_q <= alu_res;
    end

    assign rd_sel_o = rd_sel_q;
    assign store_o  = store_q;
    assign result_o = result_q;

endmodule

// File: cpu_regfile.sv
`timescale 1ns/1ps

module cpu_regfile import cpu_isa_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  reg_sel_e    rs_sel_i,
    input  reg_sel_e    rt_sel_i,
    input  reg_sel_e    wb_sel_i,
    input  logic [31:0] wb_val_i,
    input  logic        dec_n_i,
    output logic [31:0] rs_val_o,
    output logic [31:0] rt_val_o,
    output logic [31:0] sl_val_o,
    output logic        n_zero_o
);

    // General registers A to J
    logic [31:0] gpr_q [1:10];
    logic [31:0] sl_q;
    logic [31:0] sh_q;
    logic [31:0] n_q;
    logic        n_zero_q;
    logic [31:0] rs_val_q;
    logic [31:0] rt_val_q;

    function automatic logic [31:0] read_sel(input reg_sel_e sel);
        logic [31:0] v;
        case (sel)
            SEL_ZERO, SEL_RA, SEL_PC: v = 32'd0;
            SEL_SL:                   v = sl_q;
            SEL_SH:                   v = sh_q;
            SEL_N:                    v = n_q;
            default:                  v = gpr_q[sel];
        endcase
        return v;
    endfunction

    always_ff @(posedge clk) begin
        rs_val_q <= read_sel(rs_sel_i);
        rt_val_q <= read_sel(rt_sel_i);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i <= 10; i++) begin
                gpr_q[i] <= 32'd0;
            end
            sl_q     <= 32'd0;
            sh_q     <= 32'd0;
            n_q      <= 32'd0;
            n_zero_q <= 1'b1;
        end else begin
            case (wb_sel_i)
                SEL_A, SEL_B, SEL_C, SEL_D, SEL_E,
                SEL_F, SEL_G, SEL_H, SEL_I, SEL_J: gpr_q[wb_sel_i] <= wb_val_i;
                SEL_SL:  sl_q <= wb_val_i;
                SEL_SH:  sh_q <= wb_val_i;
                default: ;
            endcase
            // Writeback wins over the repeat countdown
            if (wb_sel_i == SEL_N) begin
                n_q      <= wb_val_i;
                n_zero_q <= (wb_val_i == 32'd0);
            end else if (dec_n_i) begin
                n_q      <= n_q - 32'd1;
                n_zero_q <= (n_q == 32'd1);
            end
        end
    end

    assign rs_val_o = rs_val_q;
    assign rt_val_o = rt_val_q;
    assign sl_val_o = sl_q;
    assign n_zero_o = n_zero_q;

endmodule

// File: cpu_decode.sv
`timescale 1ns/1ps

module cpu_decode import cpu_isa_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] inst_i,
    input  logic        n_zero_i,
    output dcd_t        dcd_o,
    output logic        hold_o,
    output logic        dec_n_o
);

    dcd_t dcd_q;

    function automatic dcd_t decode(input logic [31:0] inst);
        dcd_t d;
        logic reg_form;
        reg_form = !inst[INST_IMM_EN_BIT];
        d.rs     = reg_sel_e'(inst[INST_RS_LSB +: REG_SEL_W]);
        d.rt     = reg_sel_e'(inst[INST_RT_LSB +: REG_SEL_W]);
        d.rd     = reg_sel_e'(inst[INST_RD_LSB +: REG_SEL_W]);
        d.op     = alu_op_e'(inst[INST_ALU_LSB +: ALU_OP_W]);
        d.imm_en = inst[INST_IMM_EN_BIT];
        d.imm    = {{16{inst[INST_IMM_MSB]}}, inst[INST_IMM_MSB:0]};
        d.load   = reg_form && inst[INST_LOAD_BIT];
        d.store  = inst[INST_STORE_BIT];
        d.rpt    = reg_form && inst[INST_REPEAT_BIT];
        // Jumps are not supported
        if (inst[INST_JUMP_BIT]) begin
            d = DCD_NOP;
        end
        return d;
    endfunction

    // Repeat pending while n is still nonzero
    assign hold_o  = dcd_q.rpt && !n_zero_i;
    assign dec_n_o = hold_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            dcd_q <= DCD_NOP;
        end else if (!hold_o) begin
            dcd_q <= decode(inst_i);
        end
    end

    assign dcd_o = dcd_q;

endmodule

// File: cpu_fetch.sv
`timescale 1ns/1ps

module cpu_fetch #(
    parameter logic [31:0] RESET_PC = 32'd0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        hold_i,
    output logic [31:0] p_addr_o
);

    logic [31:0] pc_q;

    // Word addressed, one instruction per step
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (!hold_i) begin
            pc_q <= pc_q + 32'd1;
        end
    end

    assign p_addr_o = pc_q;

endmodule

// File: cpu_bus_pkg.sv
package cpu_bus_pkg;

    localparam int BUS_AW = 32;
    localparam int BUS_DW = 32;

    // R bus read request
    typedef struct packed {
        logic              rd;
        logic [BUS_AW-1:0] addr;
    } load_req_t;

    // C bus write request
    typedef struct packed {
        logic              we;
        logic [BUS_AW-1:0] addr;
        logic [BUS_DW-1:0] data;
    } store_req_t;

endpackage

// File: cpu_isa_pkg.sv
package cpu_isa_pkg;

    // Instruction word field positions
    localparam int INST_JUMP_BIT   = 31;
    localparam int INST_STORE_BIT  = 28;
    localparam int INST_RD_LSB     = 24;
    localparam int INST_ALU_LSB    = 21;
    localparam int INST_RS_LSB     = 17;
    localparam int INST_IMM_EN_BIT = 16;
    localparam int INST_IMM_MSB    = 15;
    localparam int INST_REPEAT_BIT = 12;
    localparam int INST_RT_LSB     = 8;
    localparam int INST_LOAD_BIT   = 1;

    localparam int REG_SEL_W = 4;
    localparam int ALU_OP_W  = 3;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_OR    = 3'd2,
        ALU_AND   = 3'd3,
        ALU_XOR   = 3'd4,
        ALU_RESV  = 3'd5,
        ALU_CLAMP = 3'd6,
        ALU_MUL   = 3'd7
    } alu_op_e;

    typedef enum logic [REG_SEL_W-1:0] {
        SEL_ZERO = 4'd0,
        SEL_A    = 4'd1,
        SEL_B    = 4'd2,
        SEL_C    = 4'd3,
        SEL_D    = 4'd4,
        SEL_E    = 4'd5,
        SEL_F    = 4'd6,
        SEL_G    = 4'd7,
        SEL_H    = 4'd8,
        SEL_I    = 4'd9,
        SEL_J    = 4'd10,
        SEL_RA   = 4'd11,
        SEL_SL   = 4'd12,
        SEL_SH   = 4'd13,
        SEL_N    = 4'd14,
        SEL_PC   = 4'd15
    } reg_sel_e;

    // load and rpt only valid in register form
    typedef struct packed {
        reg_sel_e    rs;
        reg_sel_e    rt;
        reg_sel_e    rd;
        alu_op_e     op;
        logic        imm_en;
        logic [31:0] imm;
        logic        load;
        logic        store;
        logic        rpt;
    } dcd_t;

    localparam dcd_t DCD_NOP = '{
        rs: SEL_ZERO, rt: SEL_ZERO, rd: SEL_ZERO, op: ALU_ADD,
        imm_en: 1'b0, imm: 32'd0, load: 1'b0, store: 1'b0, rpt: 1'b0
    };

endpackage
